/* hdmi_bob_top.f */
+incdir+common
common/video_pkg.sv
common/line_pkg.sv
logic/video_timing.sv
capture/line_capture.sv
capture/line_buffer_bank.sv
display/line_scheduler.sv
logic/video_out.sv
logic/hdmi_bob_top.sv
verification/tb_hdmi_bob_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the hdmi_bob_top testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hdmi_bob_top \
    -Mdir obj_dir \
    -f hdmi_bob_top.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_hdmi_bob_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "run_sim: pass message not found"
exit 1

/* verification/tb_hdmi_bob_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_bob_cfg.svh"

module tb_hdmi_bob_top;

    localparam int     NUM_LINES   = 500;
    localparam longint WATCHDOG_NS = 64'd6 * `H_TOTAL * `V_TOTAL * 40;

    logic              pix_clk;
    logic              cam_pclk;
    logic              resetn;
    logic              cam_line_valid;
    logic              cam_y_valid;
    video_pkg::pixel_t cam_y;
    video_pkg::pixel_t pix_y;
    logic              out_de;
    logic              out_hsync;
    logic              out_vsync;

    int                pixel_errors;
    int                count_errors;
    int                other_errors;
    int                frames_seen;
    bit                first_line_done;
    bit                content_started;
    bit                steady;
    video_pkg::pixel_t final_line;

    hdmi_bob_top i_hdmi_bob_top (
        .pix_clk        (pix_clk),
        .resetn         (resetn),
        .cam_pclk       (cam_pclk),
        .cam_line_valid (cam_line_valid),
        .cam_y_valid    (cam_y_valid),
        .cam_y          (cam_y),
        .pix_y          (pix_y),
        .out_de         (out_de),
        .out_hsync      (out_hsync),
        .out_vsync      (out_vsync)
    );

    initial begin
        pix_clk = 1'b0;
        forever #20 pix_clk = ~pix_clk;
    end

    initial begin
        cam_pclk = 1'b0;
        forever #18.5 cam_pclk = ~cam_pclk;
    end

    // pixel x of camera line k
    function automatic video_pkg::pixel_t ref_pixel(input int line_no, input int x);
        return video_pkg::pixel_t'(line_no + x);
    endfunction

    task automatic check_pixel(input string name, input video_pkg::pixel_t got,
                               input video_pkg::pixel_t exp);
        if (got !== exp) begin
            pixel_errors++;
            if (pixel_errors <= 20) begin
                $display("ERROR %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
            end
        end
    endtask

    task automatic check_count(input string name, input video_pkg::h_count_t got,
                               input video_pkg::h_count_t exp);
        if (got !== exp) begin
            count_errors++;
            if (count_errors <= 20) begin
                $display("ERROR %s: got 0x%03h, expected 0x%03h at %0t", name, got, exp, $time);
            end
        end
    endtask

    // ------------------------------
    // camera model
    // ------------------------------
    task automatic send_line(input int k);
        int len;
        int x;
        len = `H_ACTIVE + int'($urandom % 24);
        x = 0;
        @(posedge cam_pclk);
        #2;
        cam_line_valid = 1'b1;
        while (x < len) begin
            // the odd idle strobe inside a line
            if ($urandom % 16 == 0) begin
                cam_y_valid = 1'b0;
            end else begin
                cam_y_valid = 1'b1;
                cam_y = ref_pixel(k, x);
                x++;
            end
            @(posedge cam_pclk);
            #2;
        end
        cam_y_valid    = 1'b0;
        cam_line_valid = 1'b0;
        cam_y          = '0;
    endtask

    // ------------------------------
    // compare process
    // ------------------------------
    initial begin : compare
        int                col;
        int                row;
        int                hs_low;
        int                vs_lines;
        bit                de_q;
        bit                hs_q;
        bit                vs_q;
        bit                blank_row;
        bit                prev_valid;
        video_pkg::pixel_t y0;
        video_pkg::pixel_t pair_line;
        video_pkg::pixel_t prev_pair;
        video_pkg::pixel_t diff;
        col = 0;
        row = 0;
        hs_low = 0;
        vs_lines = 0;
        de_q = 1'b0;
        hs_q = 1'b1;
        vs_q = 1'b1;
        blank_row = 1'b1;
        prev_valid = 1'b0;
        y0 = '0;
        pair_line = '0;
        prev_pair = '0;
        wait (resetn === 1'b1);
        forever begin
            @(negedge pix_clk);
            if (out_de) begin
                if (col == 0) begin
                    y0 = pix_y;
                    if (!first_line_done) begin
                        check_pixel("pix_y before first line", y0, 8'h00);
                    end
                    blank_row = !content_started && (y0 == 8'h00);
                    if (!blank_row) begin
                        content_started = 1'b1;
                    end
                    if (row % 2 == 0) begin
                        // line numbers move forward, modulo 256
                        diff = y0 - prev_pair;
                        if (!blank_row && prev_valid && diff >= 8'd128) begin
                            other_errors++;
                            $display("line order went backwards: line 0x%02h after 0x%02h",
                                     y0, prev_pair);
                        end
                        if (steady) begin
                            check_pixel("pix_y column 0 after last line", y0, final_line);
                        end
                        pair_line  = y0;
                        prev_pair  = y0;
                        prev_valid = !blank_row;
                    end else begin
                        check_pixel("pix_y column 0 of second row", y0, pair_line);
                    end
                end
                if (blank_row) begin
                    check_pixel("pix_y", pix_y, 8'h00);
                end else begin
                    check_pixel("pix_y", pix_y, ref_pixel(y0, col));
                end
                col++;
            end else if (de_q) begin
                check_count("out_de cycles per row", video_pkg::h_count_t'(col), `H_ACTIVE);
                col = 0;
                row++;
            end
            // sync pulse widths
            if (!out_hsync) begin
                hs_low++;
            end else if (!hs_q) begin
                check_count("out_hsync low cycles", video_pkg::h_count_t'(hs_low), `H_SYNC);
                hs_low = 0;
            end
            if (!out_hsync && hs_q && !out_vsync) begin
                vs_lines++;
            end
            if (!out_vsync && vs_q) begin
                check_count("out_de rows per frame", video_pkg::h_count_t'(row), `V_ACTIVE);
                row = 0;
                frames_seen++;
            end
            if (out_vsync && !vs_q) begin
                check_count("out_vsync low lines", video_pkg::h_count_t'(vs_lines), `V_SYNC);
                vs_lines = 0;
            end
            de_q = out_de;
            hs_q = out_hsync;
            vs_q = out_vsync;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within six frames");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin : main
        int f0;
        void'($urandom(15806));
        resetn          = 1'b0;
        cam_line_valid  = 1'b0;
        cam_y_valid     = 1'b0;
        cam_y           = '0;
        pixel_errors    = 0;
        count_errors    = 0;
        other_errors    = 0;
        frames_seen     = 0;
        first_line_done = 1'b0;
        content_started = 1'b0;
        steady          = 1'b0;
        final_line      = video_pkg::pixel_t'(NUM_LINES);
        repeat (8) @(posedge pix_clk);
        #2;
        resetn = 1'b1;

        // bursts faster than the display drains them
        for (int k = 1; k < NUM_LINES; k++) begin
            send_line(k);
            first_line_done = 1'b1;
            repeat (4 + $urandom % 40) @(posedge cam_pclk);
            if (k % 32 == 0) begin
                repeat (500 + $urandom % 3000) @(posedge cam_pclk);
            end
        end
        // long pause lets every buffer come back, so the last line is kept
        repeat (`H_TOTAL * 80) @(posedge cam_pclk);
        send_line(NUM_LINES);

        f0 = frames_seen;
        wait (frames_seen >= f0 + 1);
        steady = 1'b1;
        wait (frames_seen >= f0 + 3);
        @(negedge pix_clk);

        if (!content_started) begin
            other_errors++;
            $display("no captured line was ever shown");
        end
        $display("errors: pixel %0d, count %0d, other %0d",
                 pixel_errors, count_errors, other_errors);
        if (pixel_errors + count_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/hdmi_bob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_bob_top (
    input  logic              pix_clk,
    input  logic              resetn,
    input  logic              cam_pclk,
    input  logic              cam_line_valid,
    input  logic              cam_y_valid,
    input  video_pkg::pixel_t cam_y,
    output video_pkg::pixel_t pix_y,
    output logic              out_de,
    output logic              out_hsync,
    output logic              out_vsync
);

    video_pkg::h_count_t  h_count;
    video_pkg::v_count_t  v_count;
    logic                 de;
    logic                 hsync;
    logic                 vsync;
    logic                 wr_en;
    line_pkg::buf_idx_t   wr_buf;
    line_pkg::line_addr_t wr_addr;
    video_pkg::pixel_t    wr_data;
    line_pkg::buf_idx_t   desc_buf;
    logic                 desc_toggle;
    line_pkg::buf_mask_t  rel_mask;
    logic                 rel_toggle;
    line_pkg::buf_idx_t   cur_buf;
    logic                 cur_valid;
    video_pkg::pixel_t    rd_data;

    video_timing i_video_timing (
        .pix_clk (pix_clk),
        .resetn  (resetn),
        .h_count (h_count),
        .v_count (v_count),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    // ------------------------------
    // camera domain
    // ------------------------------
    line_capture i_line_capture (
        .cam_pclk       (cam_pclk),
        .resetn         (resetn),
        .cam_line_valid (cam_line_valid),
        .cam_y_valid    (cam_y_valid),
        .cam_y          (cam_y),
        .rel_mask       (rel_mask),
        .rel_toggle     (rel_toggle),
        .wr_en          (wr_en),
        .wr_buf         (wr_buf),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .desc_buf       (desc_buf),
        .desc_toggle    (desc_toggle)
    );

    line_buffer_bank i_line_buffer_bank (
        .cam_pclk (cam_pclk),
        .pix_clk  (pix_clk),
        .wr_en    (wr_en),
        .wr_buf   (wr_buf),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .h_count  (h_count),
        .cur_buf  (cur_buf),
        .rd_data  (rd_data)
    );

    // ------------------------------
    // display domain
    // ------------------------------
    line_scheduler i_line_scheduler (
        .pix_clk     (pix_clk),
        .resetn      (resetn),
        .desc_buf    (desc_buf),
        .desc_toggle (desc_toggle),
        .de          (de),
        .v_count     (v_count),
        .cur_buf     (cur_buf),
        .cur_valid   (cur_valid),
        .rel_mask    (rel_mask),
        .rel_toggle  (rel_toggle)
    );

    video_out i_video_out (
        .pix_clk   (pix_clk),
        .resetn    (resetn),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync),
        .rd_data   (rd_data),
        .cur_valid (cur_valid),
        .pix_y     (pix_y),
        .out_de    (out_de),
        .out_hsync (out_hsync),
        .out_vsync (out_vsync)
    );

endmodule

`default_nettype wire

/* logic/video_out.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out (
    input  logic              pix_clk,
    input  logic              resetn,
    input  logic              de,
    input  logic              hsync,
    input  logic              vsync,
    input  video_pkg::pixel_t rd_data,
    input  logic              cur_valid,
    output video_pkg::pixel_t pix_y,
    output logic              out_de,
    output logic              out_hsync,
    output logic              out_vsync
);

    // stage 1 lines up with the memory read
    logic de_d;
    logic hsync_d;
    logic vsync_d;

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            de_d      <= 1'b0;
            hsync_d   <= 1'b1;
            vsync_d   <= 1'b1;
            pix_y     <= '0;
            out_de    <= 1'b0;
            out_hsync <= 1'b1;
            out_vsync <= 1'b1;
        end else begin
            de_d      <= de;
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            out_de    <= de_d;
            out_hsync <= hsync_d;
            out_vsync <= vsync_d;
            // black until the first line is on screen
            pix_y     <= (de_d && cur_valid) ? rd_data : '0;
        end
    end

endmodule

`default_nettype wire

/* display/line_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_bob_cfg.svh"

module line_scheduler (
    input  logic                 pix_clk,
    input  logic                 resetn,
    input  line_pkg::buf_idx_t   desc_buf,
    input  logic                 desc_toggle,
    input  logic                 de,
    input  video_pkg::v_count_t  v_count,
    output line_pkg::buf_idx_t   cur_buf,
    output logic                 cur_valid,
    output line_pkg::buf_mask_t  rel_mask,
    output logic                 rel_toggle
);

    localparam int PTR_W  = $clog2(`DESC_DEPTH);
    localparam int HOLD_W = $clog2(`REL_HOLD + 1);

    logic [`SYNC_STAGES-1:0]  desc_sync;
    line_pkg::buf_idx_t       fifo [`DESC_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    line_pkg::desc_count_t    desc_count;
    logic                     push;
    logic                     de_d;
    logic                     pop_req;
    logic                     pop;
    line_pkg::buf_mask_t      rel_accum;
    line_pkg::buf_mask_t      rel_add;
    logic [HOLD_W-1:0]        hold_cnt;
    logic                     send;

    // ------------------------------
    // descriptor receive and FIFO
    // ------------------------------
    // desc_buf is stable by the time the toggle shows up here
    assign push = desc_sync[`SYNC_STAGES-1] ^ desc_sync[`SYNC_STAGES-2];

    always_ff @(posedge pix_clk) begin
        if (push) begin
            fifo[wr_ptr] <= desc_buf;
        end
    end

    // bob: pop on even rows only, odd rows repeat the line
    assign pop_req = de && !de_d && !v_count[0];
    assign pop     = pop_req && (desc_count != '0);

    // the line leaving the screen goes back to the camera side
    assign rel_add = (pop && cur_valid) ? (line_pkg::buf_mask_t'(1) << cur_buf) : '0;
    assign send    = (hold_cnt == '0) && (rel_accum != '0);

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            desc_sync  <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            desc_count <= '0;
            de_d       <= 1'b0;
            cur_buf    <= '0;
            cur_valid  <= 1'b0;
        end else begin
            desc_sync  <= {desc_sync[`SYNC_STAGES-2:0], desc_toggle};
            de_d       <= de;
            desc_count <= desc_count + line_pkg::desc_count_t'(push)
                                     - line_pkg::desc_count_t'(pop);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // empty FIFO keeps showing the current line
            if (pop) begin
                rd_ptr    <= rd_ptr + 1'b1;
                cur_buf   <= fifo[rd_ptr];
                cur_valid <= 1'b1;
            end
        end
    end

    // ------------------------------
    // release sender
    // ------------------------------
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            rel_accum  <= '0;
            rel_mask   <= '0;
            rel_toggle <= 1'b0;
            hold_cnt   <= '0;
        end else begin
            if (send) begin
                rel_mask   <= rel_accum;
                rel_toggle <= ~rel_toggle;
                hold_cnt   <= HOLD_W'(`REL_HOLD);
                rel_accum  <= rel_add;
            end else begin
                rel_accum <= rel_accum | rel_add;
                if (hold_cnt != '0) begin
                    hold_cnt <= hold_cnt - 1'b1;
                end
            end
        end
    end

    // camera side never has more lines in flight than FIFO slots
    a_no_overflow: assert property (@(posedge pix_clk) disable iff (!resetn)
        push |-> desc_count < `DESC_DEPTH);

    // a pop never reads past the write side of the FIFO
    a_no_underflow: assert property (@(posedge pix_clk) disable iff (!resetn)
        pop |-> (rd_ptr != wr_ptr) || (desc_count == `DESC_DEPTH));

endmodule

`default_nettype wire

/* capture/line_buffer_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_bob_cfg.svh"

module line_buffer_bank (
    input  logic                 cam_pclk,
    input  logic                 pix_clk,
    input  logic                 wr_en,
    input  line_pkg::buf_idx_t   wr_buf,
    input  line_pkg::line_addr_t wr_addr,
    input  video_pkg::pixel_t    wr_data,
    input  video_pkg::h_count_t  h_count,
    input  line_pkg::buf_idx_t   cur_buf,
    output video_pkg::pixel_t    rd_data
);

    video_pkg::pixel_t    mem [`NUM_BUFS][`H_ACTIVE];
    video_pkg::pixel_t    rd_q [`NUM_BUFS];
    line_pkg::line_addr_t rd_addr;

    // camera side, wr_buf picks the memory
    always_ff @(posedge cam_pclk) begin
        if (wr_en) begin
            mem[wr_buf][wr_addr] <= wr_data;
        end
    end

    // blanking reads park on address 0
    assign rd_addr = (h_count < `H_ACTIVE) ? line_pkg::line_addr_t'(h_count) : '0;

    // all memories read in parallel
    always_ff @(posedge pix_clk) begin
        for (int b = 0; b < `NUM_BUFS; b++) begin
            rd_q[b] <= mem[b][rd_addr];
        end
    end

    // select after the read, so a buffer switch at the row start
    // already applies to column 0
    assign rd_data = rd_q[cur_buf];

endmodule

`default_nettype wire

/* capture/line_capture.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_bob_cfg.svh"

module line_capture (
    input  logic                   cam_pclk,
    input  logic                   resetn,
    input  logic                   cam_line_valid,
    input  logic                   cam_y_valid,
    input  video_pkg::pixel_t      cam_y,
    input  line_pkg::buf_mask_t    rel_mask,
    input  logic                   rel_toggle,
    output logic                   wr_en,
    output line_pkg::buf_idx_t     wr_buf,
    output line_pkg::line_addr_t   wr_addr,
    output video_pkg::pixel_t      wr_data,
    output line_pkg::buf_idx_t     desc_buf,
    output logic                   desc_toggle
);

    logic                     line_valid_d;
    logic                     dropped;
    line_pkg::buf_mask_t      free_map;
    line_pkg::buf_mask_t      claim_mask;
    line_pkg::buf_mask_t      rel_set;
    line_pkg::buf_idx_t       alloc_idx;
    line_pkg::buf_idx_t       line_buf;
    line_pkg::line_addr_t     addr;
    logic                     line_start;
    logic                     line_end;
    logic                     claim;
    logic                     keep;
    logic [`SYNC_STAGES-1:0]  rel_sync;
    logic                     rel_new;

    assign line_start = cam_line_valid && !line_valid_d;
    assign line_end   = !cam_line_valid && line_valid_d;

    // lowest free buffer wins
    always_comb begin
        alloc_idx = '0;
        for (int i = `NUM_BUFS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_idx = line_pkg::buf_idx_t'(i);
            end
        end
    end

    assign claim      = line_start && (free_map != '0);
    assign claim_mask = claim ? (line_pkg::buf_mask_t'(1) << alloc_idx) : '0;

    // ------------------------------
    // write port
    // ------------------------------
    // the first cycle of a line already writes to the new buffer
    assign keep    = line_start ? claim : !dropped;
    assign wr_buf  = line_start ? alloc_idx : line_buf;
    assign wr_addr = line_start ? '0 : addr;
    assign wr_en   = cam_line_valid && cam_y_valid && keep && (wr_addr < `H_ACTIVE);
    assign wr_data = cam_y;

    // release toggle from the display side
    // rel_mask is held long enough to be read without its own flops
    assign rel_new = rel_sync[`SYNC_STAGES-1] ^ rel_sync[`SYNC_STAGES-2];
    assign rel_set = rel_new ? rel_mask : '0;

    always_ff @(posedge cam_pclk or negedge resetn) begin
        if (!resetn) begin
            line_valid_d <= 1'b0;
            dropped      <= 1'b0;
            free_map     <= '1;
            line_buf     <= '0;
            addr         <= '0;
            rel_sync     <= '0;
            desc_buf     <= '0;
            desc_toggle  <= 1'b0;
        end else begin
            line_valid_d <= cam_line_valid;
            rel_sync     <= {rel_sync[`SYNC_STAGES-2:0], rel_toggle};
            free_map     <= (free_map | rel_set) & ~claim_mask;

            if (line_start) begin
                line_buf <= alloc_idx;
                dropped  <= !claim;
            end

            if (wr_en) begin
                addr <= wr_addr + 1'b1;
            end else if (line_start) begin
                addr <= '0;
            end

            // descriptor for a kept line
            if (line_end && !dropped) begin
                desc_buf    <= line_buf;
                desc_toggle <= ~desc_toggle;
            end
        end
    end

    // buffer under write stays claimed until its line is done
    a_claim_free: assert property (@(posedge cam_pclk) disable iff (!resetn)
        wr_en && !line_start |-> !free_map[wr_buf]);

    // display only releases buffers the camera side gave away
    a_rel_owned: assert property (@(posedge cam_pclk) disable iff (!resetn)
        rel_new |-> (rel_mask & free_map) == '0);

endmodule

`default_nettype wire

/* logic/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_bob_cfg.svh"

module video_timing (
    input  logic                pix_clk,
    input  logic                resetn,
    output video_pkg::h_count_t h_count,
    output video_pkg::v_count_t v_count,
    output logic                de,
    output logic                hsync,
    output logic                vsync
);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (h_count == `H_TOTAL - 1);
    assign v_wrap = (v_count == `V_TOTAL - 1);

    // free-running raster counters
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_wrap) begin
                h_count <= '0;
                if (v_wrap) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    assign de = (h_count < `H_ACTIVE) && (v_count < `V_ACTIVE);

    // syncs are active low
    assign hsync = !((h_count >= `H_ACTIVE + `H_FP) &&
                     (h_count < `H_ACTIVE + `H_FP + `H_SYNC));

    assign vsync = !((v_count >= `V_ACTIVE + `V_FP) &&
                     (v_count < `V_ACTIVE + `V_FP + `V_SYNC));

endmodule

`default_nettype wire

/* common/line_pkg.sv */
`default_nettype none

package line_pkg;

    // index of one of the eight line buffers
    typedef logic [2:0] buf_idx_t;

    // one bit per buffer
    typedef logic [7:0] buf_mask_t;

    // pixel address inside a line buffer
    typedef logic [9:0] line_addr_t;

    // descriptor FIFO fill level, 0 to 8
    typedef logic [3:0] desc_count_t;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    // raster position, h wraps at 858 and v at 525
    typedef logic [10:0] h_count_t;
    typedef logic [9:0] v_count_t;

    // 8-bit luma sample
    typedef logic [7:0] pixel_t;

endpackage

`default_nettype wire

/* common/hdmi_bob_cfg.svh */
`ifndef HDMI_BOB_CFG_SVH
`define HDMI_BOB_CFG_SVH

// ------------------------------
// 720x480 raster timing
// ------------------------------
`define H_ACTIVE 720
`define H_FP 16
`define H_SYNC 62
`define H_BP 60
`define H_TOTAL (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

`define V_ACTIVE 480
`define V_FP 9
`define V_SYNC 6
`define V_BP 30
`define V_TOTAL (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// ------------------------------
// line storage
// ------------------------------
`define NUM_BUFS 8
// one slot per buffer, so the FIFO can never overflow
`define DESC_DEPTH `NUM_BUFS

// flops per toggle synchronizer
`define SYNC_STAGES 3

// pix cycles that rel_mask is held after a send
`define REL_HOLD 4

`endif
